/* design/uwb_pkg.sv */
package uwb_pkg;

    // Wishbone bus geometry
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Bytes carried on the serial line per field
    localparam int ADDR_BYTES = ADDR_W / 8;
    localparam int DATA_BYTES = DATA_W / 8;

    // Command byte values sent by the host
    typedef enum logic [7:0] {
        CMD_READ  = 8'h01,
        CMD_WRITE = 8'hAA
    } cmd_e;

    // Decoded request handed to the execute stage
    typedef struct packed {
        logic              we;   // 1 = write
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;  // Write data, don't care on reads
    } wb_req_t;

    // Read result handed to the serializer
    typedef struct packed {
        logic [DATA_W-1:0] dat;
    } rd_resp_t;

    // Master to slave Wishbone signals
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_m2s_t;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_i,
    input  logic       start_rx_i,  // Receiver ignores the line while low
    output logic [7:0] byte_o,
    output logic       valid_o      // One cycle pulse per good byte
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_cnt_q;
    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             rx_prev_q;  // For falling edge detection
    logic [7:0]       shift_q;

    // Two flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= '0;
                    if (start_rx_i && rx_prev_q && !rx_sync_q) state_q <= START;
                end
                START: begin
                    if (clk_cnt_q == HALF_BIT) begin  // Middle of start bit
                        clk_cnt_q <= '0;
                        state_q   <= rx_sync_q ? IDLE : DATA;  // Glitch goes back to idle
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                DATA: begin
                    if (clk_cnt_q == FULL_BIT) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) state_q <= STOP;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                STOP: begin
                    if (clk_cnt_q == FULL_BIT) begin
                        valid_o <= rx_sync_q;  // Bad stop bit drops the frame
                        state_q <= IDLE;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == DATA && clk_cnt_q == FULL_BIT) shift_q <= {rx_sync_q, shift_q[7:1]};
    end

    assign byte_o = shift_q;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] byte_i,
    input  logic       valid_i,  // Taken only while ready_o is high
    output logic       tx_o,
    output logic       ready_o
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic {IDLE, SHIFT} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [3:0]       bit_cnt_q;  // 0 is start bit, 9 is stop bit
    logic [8:0]       shift_q;    // Data bits then stop bit

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            tx_o      <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (valid_i) begin
                        tx_o      <= 1'b0;  // Start bit
                        clk_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (clk_cnt_q == FULL_BIT) begin
                        clk_cnt_q <= '0;
                        if (bit_cnt_q == 4'd9) begin
                            state_q <= IDLE;  // Stop bit done, line stays high
                        end else begin
                            tx_o      <= shift_q[0];
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && valid_i) begin
            shift_q <= {1'b1, byte_i};
        end else if (state_q == SHIFT && clk_cnt_q == FULL_BIT) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign ready_o = (state_q == IDLE);

endmodule

/* design/cmd_decode.sv */
`timescale 1ns/10ps

module cmd_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       byte_i,
    input  logic             valid_i,
    output logic             req_o,
    output uwb_pkg::wb_req_t req_data_o,
    input  logic             ack_i
);
    typedef enum logic [1:0] {IDLE, ADDR, DATA, ISSUE} state_e;

    state_e           state_q;
    logic [1:0]       byte_cnt_q;  // Byte position inside the current field
    uwb_pkg::wb_req_t req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= IDLE;
            byte_cnt_q <= '0;
            req_o      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    byte_cnt_q <= '0;
                    if (valid_i && (byte_i == uwb_pkg::CMD_READ ||
                                    byte_i == uwb_pkg::CMD_WRITE)) begin
                        state_q <= ADDR;  // Unknown opcodes are dropped here
                    end
                end
                ADDR: begin
                    if (valid_i) begin
                        if (byte_cnt_q == 2'(uwb_pkg::ADDR_BYTES - 1)) begin
                            byte_cnt_q <= '0;
                            if (req_q.we) begin
                                state_q <= DATA;
                            end else begin
                                state_q <= ISSUE;
                                req_o   <= 1'b1;
                            end
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (valid_i) begin
                        if (byte_cnt_q == 2'(uwb_pkg::DATA_BYTES - 1)) begin
                            state_q <= ISSUE;
                            req_o   <= 1'b1;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 1'b1;
                        end
                    end
                end
                ISSUE: begin
                    // Line bytes are ignored until the handshake closes
                    if (req_o && ack_i) req_o <= 1'b0;
                    if (!req_o && !ack_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Little-endian byte assembly
    always_ff @(posedge clk) begin
        if (valid_i) begin
            case (state_q)
                IDLE:    req_q.we <= (byte_i == uwb_pkg::CMD_WRITE);
                ADDR:    req_q.adr[byte_cnt_q*8 +: 8] <= byte_i;
                DATA:    req_q.dat[byte_cnt_q*8 +: 8] <= byte_i;
                default: ;
            endcase
        end
    end

    assign req_data_o = req_q;  // Stable while req_o is high

endmodule

/* design/wb_execute.sv */
`timescale 1ns/10ps

module wb_execute (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_i,
    input  uwb_pkg::wb_req_t           req_data_i,
    output logic                       ack_o,
    output logic                       rsp_req_o,
    output uwb_pkg::rd_resp_t          rsp_data_o,
    input  logic                       rsp_ack_i,
    output uwb_pkg::wb_m2s_t           wb_o,
    input  logic [uwb_pkg::DATA_W-1:0] wb_dat_i_,
    input  logic                       wb_ack_i_
);
    typedef enum logic [1:0] {IDLE, BUS, RESP, DONE} state_e;

    state_e            state_q;
    logic              bus_q;   // Drives both cyc and stb
    uwb_pkg::cmd_e     op_q;
    uwb_pkg::wb_req_t  cur_q;   // Request held for the bus cycle
    uwb_pkg::rd_resp_t rdat_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            bus_q     <= 1'b0;
            ack_o     <= 1'b0;
            rsp_req_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        bus_q   <= 1'b1;
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    if (wb_ack_i_) begin  // bus_q is high in this state
                        bus_q <= 1'b0;
                        if (op_q == uwb_pkg::CMD_READ) begin
                            rsp_req_o <= 1'b1;
                            state_q   <= RESP;
                        end else begin
                            ack_o   <= 1'b1;
                            state_q <= DONE;
                        end
                    end
                end
                RESP: begin
                    if (rsp_req_o && rsp_ack_i) rsp_req_o <= 1'b0;
                    if (!rsp_req_o && !rsp_ack_i) begin
                        ack_o   <= 1'b1;  // Response fully sent
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            cur_q <= req_data_i;
            op_q  <= req_data_i.we ? uwb_pkg::CMD_WRITE : uwb_pkg::CMD_READ;
        end
        if (state_q == BUS && wb_ack_i_) rdat_q.dat <= wb_dat_i_;
    end

    assign wb_o = '{cyc: bus_q, stb: bus_q, we: cur_q.we, adr: cur_q.adr, dat: cur_q.dat};
    assign rsp_data_o = rdat_q;

endmodule

/* design/resp_serialize.sv */
`timescale 1ns/10ps

module resp_serialize (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_i,
    input  uwb_pkg::rd_resp_t data_i,
    output logic              ack_o,
    output logic [7:0]        tx_byte_o,
    output logic              tx_valid_o,
    input  logic              tx_ready_i
);
    typedef enum logic [1:0] {IDLE, SEND, HOLD} state_e;

    state_e                     state_q;
    logic [1:0]                 byte_cnt_q;
    logic [uwb_pkg::DATA_W-1:0] shift_q;
    logic                       take;   // Next byte goes to the transmitter

    // Wait one cycle after a pulse so ready reflects the busy transmitter
    assign take = (state_q == SEND) && tx_ready_i && !tx_valid_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= IDLE;
            byte_cnt_q <= '0;
            tx_valid_o <= 1'b0;
            ack_o      <= 1'b0;
        end else begin
            tx_valid_o <= take;
            case (state_q)
                IDLE: begin
                    byte_cnt_q <= '0;
                    if (req_i) state_q <= SEND;
                end
                SEND: begin
                    if (take) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'(uwb_pkg::DATA_BYTES - 1)) begin
                            ack_o   <= 1'b1;  // Last byte handed over
                            state_q <= HOLD;
                        end
                    end
                end
                HOLD: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // LSB byte leaves first
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            shift_q <= data_i.dat;
        end else if (take) begin
            tx_byte_o <= shift_q[7:0];
            shift_q   <= shift_q >> 8;
        end
    end

endmodule

/* design/uart_wb_bridge.sv */
`timescale 1ns/10ps

module uart_wb_bridge #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_rx_i,
    output logic                       uart_tx_o,
    input  logic                       start_rx_i,
    output uwb_pkg::wb_m2s_t           wb_o,
    input  logic [uwb_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                       wb_ack_i
);
    logic [7:0]        rx_byte;
    logic              rx_valid;
    logic              dec_req;   // Decode to execute handshake
    logic              dec_ack;
    uwb_pkg::wb_req_t  dec_data;
    logic              rsp_req;   // Execute to serializer handshake
    logic              rsp_ack;
    uwb_pkg::rd_resp_t rsp_data;
    logic [7:0]        tx_byte;
    logic              tx_valid;
    logic              tx_ready;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk       (clk),
        .rst       (rst),
        .rx_i      (uart_rx_i),
        .start_rx_i(start_rx_i),
        .byte_o    (rx_byte),
        .valid_o   (rx_valid)
    );

    cmd_decode u_dec (
        .clk       (clk),
        .rst       (rst),
        .byte_i    (rx_byte),
        .valid_i   (rx_valid),
        .req_o     (dec_req),
        .req_data_o(dec_data),
        .ack_i     (dec_ack)
    );

    wb_execute u_exe (
        .clk       (clk),
        .rst       (rst),
        .req_i     (dec_req),
        .req_data_i(dec_data),
        .ack_o     (dec_ack),
        .rsp_req_o (rsp_req),
        .rsp_data_o(rsp_data),
        .rsp_ack_i (rsp_ack),
        .wb_o      (wb_o),
        .wb_dat_i_ (wb_dat_i),
        .wb_ack_i_ (wb_ack_i)
    );

    resp_serialize u_ser (
        .clk       (clk),
        .rst       (rst),
        .req_i     (rsp_req),
        .data_i    (rsp_data),
        .ack_o     (rsp_ack),
        .tx_byte_o (tx_byte),
        .tx_valid_o(tx_valid),
        .tx_ready_i(tx_ready)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk    (clk),
        .rst    (rst),
        .byte_i (tx_byte),
        .valid_i(tx_valid),
        .tx_o   (uart_tx_o),
        .ready_o(tx_ready)
    );

endmodule

/* dv/uart_wb_bridge_props.sv */
`timescale 1ns/10ps

module uart_wb_bridge_props (
    input logic             clk,
    input logic             rst,
    input uwb_pkg::wb_m2s_t wb_i,
    input logic             wb_ack_i,
    input logic             tx_i,
    input logic             rsp_busy_i  // Some part of a read response in flight
);
    int fail_cnt = 0;  // Failed assertion count

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_i.stb |-> wb_i.cyc)
        else begin
            fail_cnt++;
            $error("stb high without cyc");
        end

    // Request held steady until the slave acks
    stb_held: assert property (@(posedge clk) disable iff (rst)
        wb_i.stb && !wb_ack_i |=> wb_i.stb && $stable(wb_i.adr) && $stable(wb_i.we)
                                  && $stable(wb_i.dat))
        else begin
            fail_cnt++;
            $error("stb dropped or request changed before ack");
        end

    stb_ends: assert property (@(posedge clk) disable iff (rst) wb_i.stb && wb_ack_i |=> !wb_i.stb)
        else begin
            fail_cnt++;
            $error("stb still high after ack");
        end

    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !wb_i.cyc && tx_i)
        else begin
            fail_cnt++;
            $error("bus or serial line not idle after reset");
        end

    tx_quiet: assert property (@(posedge clk) disable iff (rst) !rsp_busy_i |-> tx_i)
        else begin
            fail_cnt++;
            $error("uart_tx_o active with no read response");
        end

endmodule

bind uart_wb_bridge uart_wb_bridge_props u_props (
    .clk       (clk),
    .rst       (rst),
    .wb_i      (wb_o),
    .wb_ack_i  (wb_ack_i),
    .tx_i      (uart_tx_o),
    .rsp_busy_i(rsp_req | rsp_ack | tx_valid | !tx_ready)
);

/* dv/uart_wb_bridge_tb.sv */
`timescale 1ns/10ps

module uart_wb_bridge_tb;
    localparam int CPB     = 8;     // Clocks per serial bit
    localparam int TIMEOUT = 4000;  // Cycles allowed for any single wait

    logic                       clk        = 1'b0;
    logic                       rst        = 1'b1;
    logic                       uart_rx_i  = 1'b1;  // Line idles high
    logic                       start_rx_i = 1'b1;
    logic [uwb_pkg::DATA_W-1:0] wb_dat_i   = '0;
    logic                       wb_ack_i   = 1'b0;
    logic                       uart_tx_o;
    uwb_pkg::wb_m2s_t           wb_o;

    logic [31:0]      lfsr_q = 32'h098f_ac56;
    logic [31:0]      mem [256];       // Wishbone memory model
    uwb_pkg::wb_m2s_t last_req;        // Last cycle acked by the model
    int               bus_cycles = 0;
    int               wait_left  = 0;
    logic             in_cycle   = 1'b0;
    logic [7:0]       rx_bytes [$];    // Bytes seen on uart_tx_o
    int               errors = 0;
    int               checks = 0;
    int               tests  = 0;

    uart_wb_bridge #(
        .CLKS_PER_BIT(CPB)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .uart_rx_i (uart_rx_i),
        .uart_tx_o (uart_tx_o),
        .start_rx_i(start_rx_i),
        .wb_o      (wb_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_i  (wb_ack_i)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // Errors seen by checks and by the bound assertions
    function automatic int error_total();
        return errors + DUT.u_props.fail_cnt;
    endfunction

    // Fill word depends on every address bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
    end

    // Slave model with 0 to 3 wait states
    always @(posedge clk) begin
        wb_ack_i <= 1'b0;
        if (wb_o.stb && !wb_ack_i) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = rand_bits(2);
            end
            if (wait_left == 0) begin
                in_cycle = 1'b0;
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_o.adr[7:0]];
                if (wb_o.we) mem[wb_o.adr[7:0]] <= wb_o.dat;
                bus_cycles <= bus_cycles + 1;
                last_req   <= wb_o;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Serial monitor, samples each bit near its middle
    initial begin
        logic [7:0] b;
        forever begin
            @(posedge clk);
            if (!rst && !uart_tx_o) begin
                repeat (CPB / 2 - 1) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(posedge clk);
                    b[i] = uart_tx_o;
                end
                repeat (CPB) @(posedge clk);
                check_val("tx stop bit", uart_tx_o, 1);
                rx_bytes.push_back(b);
            end
        end
    end

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            uart_rx_i <= frame[i];
            repeat (CPB) @(posedge clk);
        end
    endtask

    task automatic send_frame(input logic we, input logic [15:0] adr, input logic [31:0] dat);
        send_byte(we ? uwb_pkg::CMD_WRITE : uwb_pkg::CMD_READ);
        send_byte(adr[7:0]);   // Address LSB first
        send_byte(adr[15:8]);
        if (we) begin
            for (int i = 0; i < 4; i++) send_byte(dat[i*8 +: 8]);
        end
    endtask

    task automatic wait_bus(input int target);
        int n;
        n = 0;
        while (bus_cycles < target && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (bus_cycles < target) abort_run("the bridge never started a Wishbone cycle");
    endtask

    task automatic wait_tx(input int count);
        int n;
        n = 0;
        while (rx_bytes.size() < count && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rx_bytes.size() < count) abort_run("the read response never came back on uart_tx_o");
    endtask

    task automatic do_write(input logic [15:0] adr, input logic [31:0] dat);
        int target;
        target = bus_cycles + 1;
        send_frame(1'b1, adr, dat);
        wait_bus(target);
        check_val("write we", last_req.we, 1);
        check_val("write address", last_req.adr, adr);
        check_val("write data", last_req.dat, dat);
        check_val("memory word", mem[adr[7:0]], dat);
        repeat (2 * CPB) @(posedge clk);  // Handshakes close well within this
        check_val("write cycle count", bus_cycles, target);
    endtask

    task automatic do_read(input logic [15:0] adr, output logic [31:0] got);
        int          target;
        logic [31:0] exp;
        rx_bytes.delete();
        target = bus_cycles + 1;
        exp    = mem[adr[7:0]];
        send_frame(1'b0, adr, '0);
        wait_tx(4);
        got = {rx_bytes[3], rx_bytes[2], rx_bytes[1], rx_bytes[0]};  // LSB came first
        check_val("read cycle count", bus_cycles, target);
        check_val("read we", last_req.we, 0);
        check_val("read address", last_req.adr, adr);
        check_val("read data", got, exp);
        repeat (2 * CPB) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        $display("%-16s %s", name, (error_total() == err0) ? "ok" : "mismatch");
    endtask

    initial begin
        logic [15:0] adr;
        logic [31:0] dat;
        logic [31:0] got;
        logic [31:0] old;
        int          base;
        int          err0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        err0 = error_total();
        adr  = rand_bits(16);
        dat  = rand_bits(32);
        do_write(adr, dat);
        end_test("write", err0);

        err0 = error_total();
        do_read(adr, got);
        check_val("read back", got, dat);
        end_test("read back", err0);

        err0 = error_total();
        for (int i = 0; i < 8; i++) begin
            if (rand_bits(1)) begin
                adr = rand_bits(16);
                do_write(adr, rand_bits(32));
            end else begin
                do_read(adr, got);  // Often hits the last written word
            end
        end
        end_test("mixed", err0);

        err0 = error_total();
        base = bus_cycles;
        send_byte(8'h55);  // Not an opcode
        do_read(adr, got);
        check_val("cycles after bad opcode", bus_cycles, base + 1);
        end_test("invalid opcode", err0);

        err0 = error_total();
        base = bus_cycles;
        old  = mem[adr[7:0]];
        start_rx_i <= 1'b0;
        send_frame(1'b1, adr, ~old);
        repeat (2 * CPB) @(posedge clk);
        start_rx_i <= 1'b1;
        check_val("cycles while gated", bus_cycles, base);
        do_read(adr, got);
        check_val("word after gated write", got, old);
        end_test("rx gating", err0);

        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, error_total());
        if (error_total() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* uart_wb_bridge.f */
design/uwb_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decode.sv
design/wb_execute.sv
design/resp_serialize.sv
design/uart_wb_bridge.sv
dv/uart_wb_bridge_props.sv
dv/uart_wb_bridge_tb.sv

/* Bender.yml */
package:
  name: uart_wb_bridge

sources:
  - files:
      - design/uwb_pkg.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/cmd_decode.sv
      - design/wb_execute.sv
      - design/resp_serialize.sv
      - design/uart_wb_bridge.sv
  - target: test
    files:
      - dv/uart_wb_bridge_props.sv
      - dv/uart_wb_bridge_tb.sv
